// File: verilog.f
+incdir+src
src/rv_isa_pkg.sv
src/rv_core_pkg.sv
src/rv_ctrl_if.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_pc_unit.sv
src/rv_core.sv
dv/rv_core_chk.sv
dv/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - src
    files:
      - src/rv_isa_pkg.sv
      - src/rv_core_pkg.sv
      - src/rv_ctrl_if.sv
      - src/rv_decoder.sv
      - src/rv_regfile.sv
      - src/rv_alu.sv
      - src/rv_pc_unit.sv
      - src/rv_core.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/rv_core_chk.sv
      - dv/rv_core_tb.sv

// File: dv/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core_tb;

    localparam int CLK_PERIOD  = 8;
    localparam int MEM_WORDS   = 1 << `RV_MEM_AW;
    localparam int TEST_CYCLES = 46 + 8 + 16 + 8 + 4 + 8 + 14;  // run lengths of all programs.
    localparam int RUN_LIMIT   = (TEST_CYCLES + 7 * 6 + 100) * CLK_PERIOD;

    // funct3 and bit 30 of the ten register operations, entry k at bits 3k.
    localparam logic [29:0] F3_LIST  = {3'd7, 3'd6, 3'd5, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1,
                                        3'd0, 3'd0};
    localparam logic [9:0]  ALT_LIST = 10'b00_1000_0010;  // sub and sra.

    logic                  CLK;
    logic                  RESET_N;
    logic [`RV_MEM_AW-1:0] rom_addr;
    logic [`RV_XLEN-1:0]   rom_data;
    logic [`RV_MEM_AW-1:0] ram_addr;
    logic [`RV_XLEN-1:0]   ram_rdata;
    logic [`RV_XLEN-1:0]   ram_wdata;
    logic                  ram_we;

    logic [`RV_XLEN-1:0]   rom [0:MEM_WORDS-1];
    logic [`RV_XLEN-1:0]   ram [0:MEM_WORDS-1];
    int                    wr_ptr;
    int                    exp_addr[$];
    logic [`RV_XLEN-1:0]   exp_data[$];

    rv_core i_dut (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .ram_addr  (ram_addr),
        .ram_rdata (ram_rdata),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we)
    );

    ////////////////////////////////////////////////////////////////////////////
    // clock, memory models and store monitor
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    assign rom_data  = rom[rom_addr];  // both memories read combinationally.
    assign ram_rdata = ram[ram_addr];

    always @(posedge CLK) begin
        if (ram_we) ram[ram_addr] <= ram_wdata;
    end

    // stores are sampled mid-cycle, where the core outputs have settled.
    always @(negedge CLK) begin
        if (RESET_N && ram_we) begin
            assert (exp_addr.size() != 0)
                else abort_run($sformatf("unexpected store to word %0d at %0t", ram_addr, $time));
            check_value("ram_addr", exp_addr.pop_front(), ram_addr);
            check_value("ram_wdata", exp_data.pop_front(), ram_wdata);
        end
    end

    initial begin
        #(RUN_LIMIT);
        abort_run("watchdog expired before all tests had finished");
    end

    ////////////////////////////////////////////////////////////////////////////
    // checking and instruction encoding
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    // reference for the alu operations, straight from the RV32I definitions.
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] rtype_word(input logic alt, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] imm, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] upper_word(input logic [19:0] imm, input logic [4:0] rd,
                                               input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // program loading and running
    ////////////////////////////////////////////////////////////////////////////

    task automatic clear_memories();
        for (int i = 0; i < MEM_WORDS; i++) begin
            rom[i] = itype_word(12'(i), 5'd0, 3'b000, 5'd0, 7'b0010011);  // addi x0 as filler.
            ram[i] = 32'h5a5a_0000 ^ i;
        end
        wr_ptr = 0;
    endtask

    task automatic start_test();
        @(posedge CLK);
        #1 RESET_N = 1'b0;  // the old program stops before the ROM is replaced.
        clear_memories();
    endtask

    task automatic emit(input logic [31:0] word);
        rom[wr_ptr] = word;
        wr_ptr++;
    endtask

    task automatic store_reg(input logic [4:0] rs, input int word);
        emit({7'(word >> 3), rs, 5'd0, 3'b010, 5'(word << 2), 7'b0100011});  // sw rs, 4*word(x0).
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;  // addi sign-extends its low twelve bits.
        emit(upper_word(upper[31:12], rd, 7'b0110111));
        emit(itype_word(value[11:0], rd, 3'b000, rd, 7'b0010011));
    endtask

    task automatic expect_store(input int word, input logic [31:0] value);
        exp_addr.push_back(word);
        exp_data.push_back(value);
    endtask

    task automatic run_program(input int cycles, input logic track_fetch);
        if (RESET_N) begin
            @(posedge CLK);
            #1 RESET_N = 1'b0;
        end
        repeat (4) @(posedge CLK);
        #1 RESET_N = 1'b1;
        for (int k = 0; k < cycles; k++) begin
            if (track_fetch) check_value("rom_addr", k, rom_addr);  // one word per clock.
            @(posedge CLK);
            #1;
        end
        assert (exp_addr.size() == 0)
            else abort_run($sformatf("%0d expected stores never happened", exp_addr.size()));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic arithmetic_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        start_test();
        a = $urandom();
        b = $urandom();
        load_const(5'd1, a);
        load_const(5'd2, b);
        for (int k = 0; k < 10; k++) begin
            f3  = F3_LIST[3*k +: 3];
            alt = ALT_LIST[k];
            emit(rtype_word(alt, 5'd2, 5'd1, f3, 5'd3));
            store_reg(5'd3, 16 + k);
            expect_store(16 + k, alu_ref(f3, alt, a, b));
            if (!(f3 == 3'd0 && alt)) begin  // there is no subi.
                if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, alt, 5'd0, 5'($urandom())};
                else imm = 12'($urandom());
                emit(itype_word(imm, 5'd1, f3, 5'd4, 7'b0010011));
                store_reg(5'd4, 32 + k);
                expect_store(32 + k, alu_ref(f3, alt, a, {{20{imm[11]}}, imm}));
            end
        end
        run_program(46, 1'b0);
    endtask

    task automatic memory_round_trip();
        logic [31:0] v;
        start_test();
        v = $urandom();
        load_const(5'd1, v);
        store_reg(5'd1, 40);
        emit(itype_word(12'd160, 5'd0, 3'b010, 5'd2, 7'b0000011));  // lw x2, 160(x0).
        emit(itype_word(12'd1, 5'd2, 3'b000, 5'd2, 7'b0010011));
        store_reg(5'd2, 41);
        expect_store(40, v);
        expect_store(41, v + 32'd1);
        run_program(8, 1'b0);
    endtask

    task automatic conditional_branches();
        logic [31:0] r;
        start_test();
        r = $urandom();
        load_const(5'd1, r);
        emit(itype_word(12'd0, 5'd1, 3'b000, 5'd2, 7'b0010011));     // x2 equals x1.
        emit(itype_word(12'd1, 5'd1, 3'b000, 5'd3, 7'b0010011));     // x3 differs from x1.
        emit(itype_word(12'h055, 5'd0, 3'b000, 5'd5, 7'b0010011));   // marker value.
        emit(branch_word(13'd8, 5'd2, 5'd1, 3'b000));                 // beq taken.
        store_reg(5'd5, 50);
        emit(branch_word(13'd8, 5'd3, 5'd1, 3'b000));                 // beq not taken.
        store_reg(5'd5, 51);
        emit(branch_word(13'd8, 5'd3, 5'd1, 3'b001));                 // bne taken.
        store_reg(5'd5, 52);
        emit(branch_word(13'd8, 5'd2, 5'd1, 3'b001));                 // bne not taken.
        store_reg(5'd5, 53);
        store_reg(5'd1, 54);
        expect_store(51, 32'h55);
        expect_store(53, 32'h55);
        expect_store(54, r);
        run_program(16, 1'b0);
    endtask

    task automatic link_and_auipc();
        logic [19:0] u;
        start_test();
        u = 20'($urandom());
        emit(jal_word(21'd12, 5'd7));  // word 0 jumps to word 3.
        store_reg(5'd0, 60);
        store_reg(5'd0, 61);
        emit(upper_word(u, 5'd6, 7'b0010111));  // auipc at byte address 12.
        store_reg(5'd7, 62);
        store_reg(5'd6, 63);
        expect_store(62, 32'd4);
        expect_store(63, {u, 12'h000} + 32'd12);
        run_program(8, 1'b0);
    endtask

    task automatic x0_and_restart();
        logic [31:0] v;
        start_test();
        v = $urandom();
        emit(itype_word(12'h7ff, 5'd0, 3'b000, 5'd0, 7'b0010011));
        emit(upper_word(20'($urandom()), 5'd0, 7'b0110111));
        store_reg(5'd0, 70);
        load_const(5'd1, v);
        store_reg(5'd1, 71);
        expect_store(70, 32'd0);
        run_program(4, 1'b0);  // reset comes back before the store to word 71.
        expect_store(70, 32'd0);
        expect_store(71, v);
        run_program(8, 1'b0);
    endtask

    task automatic fetch_sequence();
        start_test();
        for (int i = 0; i < 12; i++) begin
            emit(itype_word(12'd1, 5'd1, 3'b000, 5'd1, 7'b0010011));
        end
        store_reg(5'd1, 80);
        expect_store(80, 32'd12);
        run_program(14, 1'b1);
    endtask

    initial begin
        void'($urandom(32'ha6a6));
        RESET_N = 1'b0;
        clear_memories();
        arithmetic_ops();
        memory_round_trip();
        conditional_branches();
        link_and_auipc();
        x0_and_restart();
        fetch_sequence();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: dv/rv_core_chk.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

// Watches the register file read port and the PC unit from inside the core.
module rv_core_chk #(
    parameter int PCW = `RV_MEM_AW + 2
) (
    input logic                CLK,
    input logic                RESET_N,
    input logic [4:0]          rs1_addr,
    input logic [`RV_XLEN-1:0] rs1_data,
    input logic [PCW-1:0]      pc,
    input logic [`RV_XLEN-1:0] imm,
    input logic                we
);

    logic [PCW-1:0] seq_pc;
    logic [PCW-1:0] jump_pc;

    assign seq_pc  = pc + PCW'(4);        // sequential successor.
    assign jump_pc = pc + imm[PCW-1:0];   // branch or jump target.

    x0_reads_zero: assert property (@(posedge CLK) disable iff (!RESET_N)
        (rs1_addr == 5'd0) |-> (rs1_data == '0))
        else $error("x0 read returned a nonzero value");

    pc_aligned: assert property (@(posedge CLK) disable iff (!RESET_N) pc[1:0] == 2'b00)
        else $error("program counter lost word alignment");

    pc_steps: assert property (@(posedge CLK) disable iff (!RESET_N)
        1'b1 |=> (pc == $past(seq_pc)) || (pc == $past(jump_pc)))
        else $error("program counter moved to neither pc+4 nor pc+imm");

    we_known: assert property (@(posedge CLK) disable iff (!RESET_N) !$isunknown(we))
        else $error("ram write enable is unknown");

endmodule

bind rv_core rv_core_chk i_chk (
    .CLK      (CLK),
    .RESET_N  (RESET_N),
    .rs1_addr (rom_data[19:15]),
    .rs1_data (rs1_data),
    .pc       (pc),
    .imm      (imm),
    .we       (ram_we)
);

// File: src/rv_core.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core (
    input  logic                  CLK,
    input  logic                  RESET_N,
    output logic [`RV_MEM_AW-1:0] rom_addr,
    input  logic [`RV_XLEN-1:0]   rom_data,
    output logic [`RV_MEM_AW-1:0] ram_addr,
    input  logic [`RV_XLEN-1:0]   ram_rdata,
    output logic [`RV_XLEN-1:0]   ram_wdata,
    output logic                  ram_we
);

    localparam int PCW = `RV_MEM_AW + 2;

    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic                alu_zero;
    logic [`RV_XLEN-1:0] wb_data;
    logic [PCW-1:0]      pc;
    logic [`RV_XLEN-1:0] pc_plus4;

    rv_ctrl_if ctrl ();

    ////////////////////////////////////////////////////////////////////////////
    // decode and operands
    ////////////////////////////////////////////////////////////////////////////

    rv_decoder i_decoder (.instr(rom_data), .imm(imm), .ctrl(ctrl.dec));

    rv_regfile i_regfile (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .rs1_addr (rom_data[19:15]),
        .rs2_addr (rom_data[24:20]),
        .rd_addr  (rom_data[11:7]),
        .rd_data  (wb_data),
        .write_en (ctrl.reg_write),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    always_comb begin
        case (ctrl.src_a)
            rv_core_pkg::SRC_A_PC:   op_a = {{(`RV_XLEN-PCW){1'b0}}, pc};
            rv_core_pkg::SRC_A_ZERO: op_a = '0;
            default:                 op_a = rs1_data;
        endcase
    end

    assign op_b = ctrl.src_b_imm ? imm : rs2_data;

    ////////////////////////////////////////////////////////////////////////////
    // execute, write-back and fetch
    ////////////////////////////////////////////////////////////////////////////

    rv_alu i_alu (.a(op_a), .b(op_b), .op(ctrl.alu_op), .result(alu_result), .zero(alu_zero));

    always_comb begin
        case (ctrl.wb_sel)
            rv_core_pkg::WB_MEM: wb_data = ram_rdata;  // lw.
            rv_core_pkg::WB_PC4: wb_data = pc_plus4;   // jal link.
            default:             wb_data = alu_result;
        endcase
    end

    rv_pc_unit i_pc_unit (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .imm      (imm),
        .alu_zero (alu_zero),
        .ctrl     (ctrl.user),
        .pc       (pc),
        .pc_plus4 (pc_plus4)
    );

    assign rom_addr  = pc[PCW-1:2];                 // word address of the fetch.
    assign ram_addr  = alu_result[`RV_MEM_AW+1:2];  // word-aligned access only.
    assign ram_wdata = rs2_data;
    assign ram_we    = ctrl.mem_write;

endmodule

// File: src/rv_pc_unit.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_pc_unit (
    input  logic                   CLK,
    input  logic                   RESET_N,
    input  logic [`RV_XLEN-1:0]    imm,
    input  logic                   alu_zero,
    rv_ctrl_if.user                ctrl,
    output logic [`RV_MEM_AW+1:0]  pc,
    output logic [`RV_XLEN-1:0]    pc_plus4
);

    localparam int PCW = `RV_MEM_AW + 2;

    logic [PCW-1:0] target;   // pc plus immediate.
    logic [PCW-1:0] next_pc;
    logic           taken;

    // the link value is returned at full register width.
    assign pc_plus4 = {{(`RV_XLEN-PCW){1'b0}}, pc} + `RV_XLEN'd4;
    assign target   = pc + imm[PCW-1:0];

    always_comb begin
        case (ctrl.branch)
            rv_core_pkg::EQ:   taken = alu_zero;
            rv_core_pkg::NE:   taken = !alu_zero;
            rv_core_pkg::JUMP: taken = 1'b1;
            default:           taken = 1'b0;
        endcase
    end

    assign next_pc = taken ? target : pc_plus4[PCW-1:0];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;       // fetch restarts at address zero.
        end else begin
            pc <= next_pc;  // one instruction per clock.
        end
    end

endmodule

// File: src/rv_alu.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_alu (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  rv_core_pkg::alu_op_e op,
    output logic [`RV_XLEN-1:0] result,
    output logic                zero
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];  // only the low five bits shift.
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            rv_core_pkg::ADD:
                result = a + b;
            rv_core_pkg::SUB:
                result = a - b;
            rv_core_pkg::AND:
                result = a & b;
            rv_core_pkg::OR:
                result = a | b;
            rv_core_pkg::XOR:
                result = a ^ b;
            rv_core_pkg::SLT:
                result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
            rv_core_pkg::SLTU:
                result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
            rv_core_pkg::SLL:
                result = a << shamt;
            rv_core_pkg::SRL:
                result = a >> shamt;
            rv_core_pkg::SRA:
                result = $signed(a) >>> shamt;  // sign bit fills from the left.
            rv_core_pkg::PASS_B:
                result = b;
            default:
                result = '0;
        endcase
    end

    // branches compare through sub and this flag.
    assign zero = (result == '0);

endmodule

// File: src/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_regfile (
    input  logic                CLK,
    input  logic                RESET_N,
    input  logic [4:0]          rs1_addr,
    input  logic [4:0]          rs2_addr,
    input  logic [4:0]          rd_addr,
    input  logic [`RV_XLEN-1:0] rd_data,
    input  logic                write_en,
    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data
);

    // x0 has no storage, only x1 to x31 are kept.
    logic [`RV_XLEN-1:0] regs [1:31];

    ////////////////////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && (rd_addr != 5'd0)) begin
            regs[rd_addr] <= rd_data;  // writes to x0 are dropped.
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read ports
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
        rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];
    end

    // a value written this cycle is seen by the next instruction.

endmodule

// File: src/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_decoder (
    input  logic [`RV_XLEN-1:0] instr,
    output logic [`RV_XLEN-1:0] imm,
    rv_ctrl_if.dec              ctrl
);

    rv_isa_pkg::opcode_e opcode;
    logic [2:0]          funct3;
    logic                bit30;

    assign opcode = rv_isa_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign bit30  = instr[30];

    ////////////////////////////////////////////////////////////////////////////
    // alu control
    ////////////////////////////////////////////////////////////////////////////

    // sub exists only in register form, sra in both forms.
    function automatic rv_core_pkg::alu_op_e alu_func(
        input logic [2:0] f3,
        input logic       alt,
        input logic       is_reg
    );
        rv_core_pkg::alu_op_e op;
        case (f3)
            rv_isa_pkg::F3_ADD_SUB: op = (is_reg && alt) ? rv_core_pkg::SUB : rv_core_pkg::ADD;
            rv_isa_pkg::F3_SLL:     op = rv_core_pkg::SLL;
            rv_isa_pkg::F3_SLT:     op = rv_core_pkg::SLT;
            rv_isa_pkg::F3_SLTU:    op = rv_core_pkg::SLTU;
            rv_isa_pkg::F3_XOR:     op = rv_core_pkg::XOR;
            rv_isa_pkg::F3_SRL_SRA: op = alt ? rv_core_pkg::SRA : rv_core_pkg::SRL;
            rv_isa_pkg::F3_OR:      op = rv_core_pkg::OR;
            default:                op = rv_core_pkg::AND;
        endcase
        return op;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // main control
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl.alu_op    = rv_core_pkg::ADD;       // address and link arithmetic.
        ctrl.src_a     = rv_core_pkg::SRC_A_RS1;
        ctrl.src_b_imm = 1'b0;
        ctrl.reg_write = 1'b0;
        ctrl.wb_sel    = rv_core_pkg::WB_ALU;
        ctrl.mem_write = 1'b0;
        ctrl.branch    = rv_core_pkg::NONE;

        case (opcode)
            rv_isa_pkg::OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_func(funct3, bit30, 1'b1);
            end
            rv_isa_pkg::OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.alu_op    = alu_func(funct3, bit30, 1'b0);
            end
            rv_isa_pkg::LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.wb_sel    = rv_core_pkg::WB_MEM;
            end
            rv_isa_pkg::STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.src_b_imm = 1'b1;
            end
            rv_isa_pkg::BRANCH: begin
                ctrl.alu_op = rv_core_pkg::SUB;   // equality comes from the zero flag.
                case (funct3)
                    rv_isa_pkg::F3_BEQ: ctrl.branch = rv_core_pkg::EQ;
                    rv_isa_pkg::F3_BNE: ctrl.branch = rv_core_pkg::NE;
                    default:            ctrl.branch = rv_core_pkg::NONE;
                endcase
            end
            rv_isa_pkg::JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_core_pkg::WB_PC4;
                ctrl.branch    = rv_core_pkg::JUMP;
            end
            rv_isa_pkg::LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_a     = rv_core_pkg::SRC_A_ZERO;
                ctrl.src_b_imm = 1'b1;
                ctrl.alu_op    = rv_core_pkg::PASS_B;
            end
            rv_isa_pkg::AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_a     = rv_core_pkg::SRC_A_PC;
                ctrl.src_b_imm = 1'b1;
            end
            default: begin
                // unknown opcodes retire as a no-op.
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // immediate generation
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (opcode)
            rv_isa_pkg::OP_IMM, rv_isa_pkg::LOAD:
                imm = {{20{instr[31]}}, instr[31:20]};
            rv_isa_pkg::STORE:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv_isa_pkg::BRANCH:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            rv_isa_pkg::LUI, rv_isa_pkg::AUIPC:
                imm = {instr[31:12], 12'b0};
            rv_isa_pkg::JAL:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

// File: src/rv_ctrl_if.sv
`timescale 1ns/1ps

// Control bundle produced by the decoder for the current instruction.
interface rv_ctrl_if;

    rv_core_pkg::alu_op_e alu_op;     // alu operation.
    rv_core_pkg::src_a_e  src_a;      // operand a source.
    logic                 src_b_imm;  // operand b is the immediate.
    logic                 reg_write;  // rd is written at the edge.
    rv_core_pkg::wb_sel_e wb_sel;     // write-back source.
    logic                 mem_write;  // RAM store at the edge.
    rv_core_pkg::branch_e branch;     // branch kind.

    // driving side.
    modport dec (
        output alu_op, src_a, src_b_imm, reg_write, wb_sel, mem_write, branch
    );

    // consuming side.
    modport user (
        input alu_op, src_a, src_b_imm, reg_write, wb_sel, mem_write, branch
    );

endinterface

// File: src/rv_core_pkg.sv
package rv_core_pkg;

    // operation performed by the main alu.
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        PASS_B   // forwards operand b, used by lui.
    } alu_op_e;

    // source of alu operand a.
    typedef enum logic [1:0] {
        SRC_A_PC,    // auipc.
        SRC_A_ZERO,  // lui.
        SRC_A_RS1
    } src_a_e;

    // value written back to rd.
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,  // load data from the RAM.
        WB_PC4   // link address of jal.
    } wb_sel_e;

    // kind of control transfer requested by the instruction.
    typedef enum logic [1:0] {
        NONE,
        EQ,
        NE,
        JUMP
    } branch_e;

endpackage

// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // major opcodes of the supported RV32I subset
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [6:0] {
        OP     = 7'b0110011,  // register-register alu.
        OP_IMM = 7'b0010011,  // register-immediate alu.
        LOAD   = 7'b0000011,  // lw only.
        STORE  = 7'b0100011,  // sw only.
        BRANCH = 7'b1100011,  // beq and bne.
        JAL    = 7'b1101111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    ////////////////////////////////////////////////////////////////////////////
    // funct3 codes
    ////////////////////////////////////////////////////////////////////////////

    // alu group, shared by OP and OP_IMM.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;  // bit 30 picks sub on OP.
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;  // bit 30 picks sra.
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch group.
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

endpackage

// File: src/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data path and register width, fixed by the 32-bit instruction format.
`define RV_XLEN 32

// word address width of the instruction ROM and the data RAM.
`define RV_MEM_AW 10

`endif
